// File: verilog/lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// pc after reset
`define LC3B_RESET_PC 16'h0000

// architectural registers
`define LC3B_NUM_REGS 8

// fetch, decode, execute, write back
`define LC3B_STAGES 4

`endif

// File: verilog/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// lc3b encodings of the kept instructions
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_not = 4'b1001,
	op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

// instruction memory request sequencing
typedef enum logic [1:0] {
	fs_idle,
	fs_wait,
	fs_drop
} fetch_state;

endpackage : lc3b_types

// File: verilog/fetch.sv
`timescale 1ns/10ps
`include "lc3b_params.svh"

module fetch
(
	input logic clk,
	input logic arst_n,

	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output lc3b_types::lc3b_word pmem_address,

	input logic hold,
	input logic load_de,
	input logic flush_de,
	input logic br_taken,
	input lc3b_types::lc3b_word target_pc,

	output lc3b_types::lc3b_word instr,
	output lc3b_types::lc3b_word npc,
	output logic fetch_valid
);

import lc3b_types::*;

fetch_state state;
lc3b_word pc;
lc3b_word req_addr;
logic issue;
logic resp_ok;

// response hold buffer
logic buf_valid;
lc3b_word buf_instr;

// only one word in flight, and none while the buffer is full
assign issue = (state == fs_idle) && !buf_valid && !br_taken;
assign resp_ok = (state == fs_wait) && pmem_resp && !br_taken;

assign pmem_read = (state != fs_idle);
assign pmem_address = req_addr;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= fs_idle;
		pc <= `LC3B_RESET_PC;
	end else begin
		case (state)
			fs_idle: if (issue) state <= fs_wait;
			fs_wait: begin
				if (pmem_resp)
					state <= fs_idle;
				else if (br_taken)
					state <= fs_drop;
			end
			// wrong path word still on its way
			fs_drop: if (pmem_resp) state <= fs_idle;
			default: state <= fs_idle;
		endcase
		if (br_taken)
			pc <= target_pc;
		else if (issue)
			pc <= pc + 16'd2;
	end
end

always_ff @(posedge clk) begin
	if (issue)
		req_addr <= pc;
	if (resp_ok && hold)
		buf_instr <= pmem_rdata;
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		buf_valid <= 1'b0;
	else if (br_taken)
		buf_valid <= 1'b0;
	else if (buf_valid)
		buf_valid <= !load_de;
	else
		buf_valid <= resp_ok && hold;
end

// fetch/decode register, fed from the buffer first
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		fetch_valid <= 1'b0;
	else if (flush_de)
		fetch_valid <= 1'b0;
	else if (load_de)
		fetch_valid <= buf_valid || resp_ok;
end

// req_addr holds still while the buffer is full
always_ff @(posedge clk) begin
	if (load_de) begin
		instr <= buf_valid ? buf_instr : pmem_rdata;
		npc <= req_addr + 16'd2;
	end
end

a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
	pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_address));

a_no_idle_resp: assert property (@(posedge clk) disable iff (!arst_n)
	!(state == fs_idle && pmem_resp));

endmodule : fetch

// File: verilog/decode.sv
`timescale 1ns/10ps
`include "lc3b_params.svh"

module decode
(
	input logic clk,
	input logic arst_n,

	input lc3b_types::lc3b_word instr,
	input lc3b_types::lc3b_word npc,
	input logic fetch_valid,
	input logic load_ex,
	input logic flush_ex,

	// write back
	input logic reg_store,
	input lc3b_types::lc3b_reg dest_reg,
	input lc3b_types::lc3b_word reg_data,
	input logic cc_store,
	input lc3b_types::lc3b_nzp cc_data,

	output lc3b_types::lc3b_opcode opcode,
	output lc3b_types::lc3b_aluop aluop,
	output lc3b_types::lc3b_word sr1_val,
	output lc3b_types::lc3b_word sr2_val,
	output logic imm_sel,
	output lc3b_types::lc3b_word imm,
	output lc3b_types::lc3b_word offset,
	output lc3b_types::lc3b_nzp nzp,
	output lc3b_types::lc3b_reg dr,
	output logic writes_reg,
	output lc3b_types::lc3b_reg sr1,
	output lc3b_types::lc3b_reg sr2,
	output logic uses_sr2,
	output logic is_branch,
	output lc3b_types::lc3b_word npc_ex,
	output logic ex_valid,
	output lc3b_types::lc3b_nzp cc
);

import lc3b_types::*;

lc3b_word regs [`LC3B_NUM_REGS];
lc3b_opcode op;
lc3b_aluop aluop_d;
logic writes_d;
lc3b_word sr1_rd;
lc3b_word sr2_rd;

assign op = lc3b_opcode'(instr[15:12]);
assign sr1 = instr[8:6];
assign sr2 = instr[2:0];
assign is_branch = (op == op_br);
assign uses_sr2 = (op == op_add || op == op_and) && !instr[5];

always_comb begin
	aluop_d = alu_pass;
	writes_d = 1'b1;
	case (op)
		op_add: aluop_d = alu_add;
		op_and: aluop_d = alu_and;
		op_not: aluop_d = alu_not;
		op_lea: aluop_d = alu_pass;
		default: writes_d = 1'b0;
	endcase
end

// write-first register file
assign sr1_rd = (reg_store && dest_reg == sr1) ? reg_data : regs[sr1];
assign sr2_rd = (reg_store && dest_reg == sr2) ? reg_data : regs[sr2];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			regs[i] <= '0;
		cc <= 3'b010;
	end else begin
		if (reg_store)
			regs[dest_reg] <= reg_data;
		if (cc_store)
			cc <= cc_data;
	end
end

// decode/execute register, a stall leaves a bubble
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		ex_valid <= 1'b0;
	else
		ex_valid <= load_ex && fetch_valid && !flush_ex;
end

always_ff @(posedge clk) begin
	if (load_ex) begin
		opcode <= op;
		aluop <= aluop_d;
		sr1_val <= sr1_rd;
		sr2_val <= sr2_rd;
		imm_sel <= instr[5];
		imm <= {{11{instr[4]}}, instr[4:0]};
		offset <= {{6{instr[8]}}, instr[8:0], 1'b0};
		nzp <= instr[11:9];
		dr <= instr[11:9];
		writes_reg <= writes_d;
		npc_ex <= npc;
	end
end

a_cc_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(cc));

endmodule : decode

// File: verilog/execute.sv
`timescale 1ns/10ps

module execute
(
	input logic clk,
	input logic arst_n,

	input lc3b_types::lc3b_opcode opcode,
	input lc3b_types::lc3b_aluop aluop,
	input lc3b_types::lc3b_word sr1_val,
	input lc3b_types::lc3b_word sr2_val,
	input logic imm_sel,
	input lc3b_types::lc3b_word imm,
	input lc3b_types::lc3b_word offset,
	input lc3b_types::lc3b_nzp nzp,
	input lc3b_types::lc3b_reg dr,
	input logic writes_reg,
	input lc3b_types::lc3b_word npc_ex,
	input logic ex_valid,
	input lc3b_types::lc3b_nzp cc,

	output logic br_taken,
	output lc3b_types::lc3b_word target_pc,
	output logic reg_store,
	output lc3b_types::lc3b_reg dest_reg,
	output lc3b_types::lc3b_word reg_data,
	output logic cc_store,
	output lc3b_types::lc3b_nzp cc_data,
	output logic wb_valid,
	output lc3b_types::lc3b_reg wb_dr,
	output logic wb_writes
);

import lc3b_types::*;

lc3b_word alu_b;
lc3b_word alu_out;
lc3b_word result;
lc3b_nzp gencc;
logic wb_sets_cc;

assign alu_b = imm_sel ? imm : sr2_val;

always_comb begin
	case (aluop)
		alu_add: alu_out = sr1_val + alu_b;
		alu_and: alu_out = sr1_val & alu_b;
		alu_not: alu_out = ~sr1_val;
		alu_pass: alu_out = alu_b;
	endcase
end

// one adder for lea and branch targets
assign target_pc = npc_ex + offset;
assign result = (opcode == op_lea) ? target_pc : alu_out;
assign gencc = result[15] ? 3'b100 : (result == '0) ? 3'b010 : 3'b001;
assign br_taken = ex_valid && (opcode == op_br) && |(nzp & cc);

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		wb_valid <= 1'b0;
	else
		wb_valid <= ex_valid;
end

always_ff @(posedge clk) begin
	wb_dr <= dr;
	wb_writes <= writes_reg;
	reg_data <= result;
	cc_data <= gencc;
	// lc3b lea leaves cc alone
	wb_sets_cc <= (opcode != op_lea);
end

assign reg_store = wb_valid && wb_writes;
assign cc_store = wb_valid && wb_writes && wb_sets_cc;
assign dest_reg = wb_dr;

// taken branch empties the stage behind it
a_br_flush: assert property (@(posedge clk) disable iff (!arst_n)
	br_taken |=> !ex_valid);

endmodule : execute

// File: verilog/pipeline_control.sv
`timescale 1ns/10ps
`include "lc3b_params.svh"

module pipeline_control
(
	input logic clk,
	input logic arst_n,

	input logic fetch_valid,
	input lc3b_types::lc3b_reg sr1,
	input lc3b_types::lc3b_reg sr2,
	input logic uses_sr2,
	input logic is_branch,
	input logic ex_valid,
	input lc3b_types::lc3b_reg dr,
	input logic writes_reg,
	input logic wb_valid,
	input lc3b_types::lc3b_reg wb_dr,
	input logic wb_writes,
	input logic br_taken,

	output logic load_de,
	output logic load_ex,
	output logic flush_de,
	output logic flush_ex,
	output logic hold
);

import lc3b_types::*;

logic run;
logic ex_hit;
logic wb_hit;
logic dep_stall;
logic br_stall;
logic stall;
logic [2:0] stall_cnt;

function automatic logic reads_reg(lc3b_reg d, lc3b_reg s1, lc3b_reg s2, logic use2);
	return (d == s1) || (use2 && (d == s2));
endfunction

assign ex_hit = ex_valid && writes_reg;
assign wb_hit = wb_valid && wb_writes;

// sr1 is checked for every opcode, extra stalls only
assign dep_stall = fetch_valid &&
	((ex_hit && reads_reg(dr, sr1, sr2, uses_sr2)) ||
	(wb_hit && reads_reg(wb_dr, sr1, sr2, uses_sr2)));
assign br_stall = fetch_valid && is_branch && (ex_hit || wb_hit);
assign stall = dep_stall || br_stall;

// nothing moves in the first cycle out of reset
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		run <= 1'b0;
	else
		run <= 1'b1;
end

assign load_de = run && !stall;
assign hold = !load_de;
// low on a stall, so execute gets a bubble
assign load_ex = run && !stall;
assign flush_de = br_taken;
assign flush_ex = br_taken;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		stall_cnt <= '0;
	else if (!stall)
		stall_cnt <= '0;
	else if (stall_cnt != 3'd7)
		stall_cnt <= stall_cnt + 3'd1;
end

a_stall_limit: assert property (@(posedge clk) disable iff (!arst_n)
	stall_cnt <= `LC3B_STAGES);

endmodule : pipeline_control

// File: verilog/mp3.sv
`timescale 1ns/10ps

module mp3
(
	input logic clk,
	input logic arst_n,

	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output lc3b_types::lc3b_word pmem_address,

	// retirement
	output logic reg_store,
	output lc3b_types::lc3b_reg dest_reg,
	output lc3b_types::lc3b_word reg_data
);

import lc3b_types::*;

// fetch/decode
lc3b_word instr;
lc3b_word npc;
logic fetch_valid;
lc3b_reg sr1;
lc3b_reg sr2;
logic uses_sr2;
logic is_branch;

// decode/execute
lc3b_opcode opcode;
lc3b_aluop aluop;
lc3b_word sr1_val;
lc3b_word sr2_val;
logic imm_sel;
lc3b_word imm;
lc3b_word offset;
lc3b_nzp nzp;
lc3b_reg dr;
logic writes_reg;
lc3b_word npc_ex;
logic ex_valid;
lc3b_nzp cc;

// execute/write back
logic br_taken;
lc3b_word target_pc;
logic cc_store;
lc3b_nzp cc_data;
logic wb_valid;
lc3b_reg wb_dr;
logic wb_writes;

// stall and load signals
logic load_de;
logic load_ex;
logic flush_de;
logic flush_ex;
logic hold;

fetch fetch_int (.*);

decode decode_int (.*);

execute execute_int (.*);

pipeline_control control_int (.*);

endmodule : mp3

// File: tb/mp3_tb.sv
`timescale 1ns/10ps
`include "lc3b_params.svh"

module mp3_tb;

import lc3b_types::*;

localparam int RAND_LEN = 160;
localparam int DIRECTED_LEN = 64;
localparam int NUM_TESTS = 6;
localparam int WATCHDOG_NS = (DIRECTED_LEN + RAND_LEN) * 4 * 40 + NUM_TESTS * 1000;

logic clk = 1'b0;
logic arst_n = 1'b0;
logic pmem_resp = 1'b0;
lc3b_word pmem_rdata = '0;
logic pmem_read;
lc3b_word pmem_address;
logic reg_store;
lc3b_reg dest_reg;
lc3b_word reg_data;

lc3b_word prog [256];
int prog_len;
lc3b_reg exp_dr [$];
lc3b_word exp_data [$];
int fails = 0;
logic [31:0] lfsr = 32'h8000c9c4;

// memory model state
logic mem_busy = 1'b0;
logic [1:0] mem_wait = '0;
logic [15:0] mem_bits;

mp3 i_dut (.*);

always #10 clk = ~clk;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

task automatic take_bits(input int n, output logic [15:0] v);
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr = lfsr_next(lfsr);
		v = {v[14:0], lfsr[0]};
	end
endtask

task automatic abort_run(input string msg);
	fails++;
	$display("%s", msg);
	$display("*** FAILED ***");
	$fatal(1);
endtask

task automatic check_reg(input string what, input lc3b_reg got, input lc3b_reg exp);
	if (got !== exp)
		abort_run($sformatf("ERR %0t: %s is r%0d, expected r%0d", $time, what, got, exp));
endtask

task automatic check_word(input string what, input lc3b_word got, input lc3b_word exp);
	if (got !== exp)
		abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp)
		abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

// 0 to 3 idle cycles, then a one-cycle response
always @(posedge clk) begin
	if (!arst_n) begin
		mem_busy = 1'b0;
		pmem_resp <= 1'b0;
	end else if (pmem_resp) begin
		pmem_resp <= 1'b0;
	end else if (pmem_read) begin
		if (!mem_busy) begin
			take_bits(2, mem_bits);
			mem_wait = mem_bits[1:0];
			mem_busy = 1'b1;
		end
		if (mem_wait == 2'd0) begin
			pmem_resp <= 1'b1;
			pmem_rdata <= prog[pmem_address[8:1]];
			mem_busy = 1'b0;
		end else begin
			mem_wait = mem_wait - 2'd1;
		end
	end
end

// retirement monitor
always @(posedge clk) begin
	if (reg_store) begin
		if (exp_dr.size() == 0)
			abort_run($sformatf("unexpected extra register write to r%0d at %0t", dest_reg, $time));
		else begin
			check_reg("dest_reg", dest_reg, exp_dr.pop_front());
			check_word("reg_data", reg_data, exp_data.pop_front());
		end
	end
end

function automatic lc3b_word enc_alu(lc3b_opcode op, lc3b_reg d, lc3b_reg s1, logic imm,
		logic [4:0] low);
	return imm ? {op, d, s1, 1'b1, low} : {op, d, s1, 3'b000, low[2:0]};
endfunction

function automatic lc3b_word enc_not(lc3b_reg d, lc3b_reg s);
	return {op_not, d, s, 6'b111111};
endfunction

function automatic lc3b_word enc_off9(lc3b_opcode op, logic [2:0] f, logic [8:0] off);
	return {op, f, off};
endfunction

task automatic put(input lc3b_word w);
	prog[prog_len] = w;
	prog_len++;
endtask

task automatic clear_program();
	// unused words are adds built from the address, so a stray one shows up
	for (int i = 0; i < 256; i++)
		prog[i] = {op_add, i[2:0], i[5:3], 1'b1, 3'b000, i[7:6]};
	prog_len = 0;
endtask

task automatic hold_reset();
	@(posedge clk);
	arst_n <= 1'b0;
	@(posedge clk);
endtask

// sequential isa model, stops at the closing branch to itself
task automatic run_model();
	lc3b_word r [`LC3B_NUM_REGS];
	lc3b_nzp m_cc;
	lc3b_word pc;
	lc3b_word ir;
	lc3b_word next_pc;
	lc3b_word res;
	lc3b_word b;
	lc3b_word off;
	lc3b_opcode op;
	logic writes;
	logic done;
	int steps;
	for (int i = 0; i < `LC3B_NUM_REGS; i++)
		r[i] = '0;
	m_cc = 3'b010;
	pc = `LC3B_RESET_PC;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 4000) begin
		ir = prog[pc[8:1]];
		next_pc = pc + 16'd2;
		op = lc3b_opcode'(ir[15:12]);
		b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
		off = {{6{ir[8]}}, ir[8:0], 1'b0};
		writes = 1'b1;
		res = '0;
		case (op)
			op_add: res = r[ir[8:6]] + b;
			op_and: res = r[ir[8:6]] & b;
			op_not: res = ~r[ir[8:6]];
			op_lea: res = next_pc + off;
			default: begin
				writes = 1'b0;
				if ((ir[11:9] & m_cc) != 3'b000) begin
					done = (next_pc + off == pc);
					next_pc = next_pc + off;
				end
			end
		endcase
		if (writes) begin
			r[ir[11:9]] = res;
			exp_dr.push_back(ir[11:9]);
			exp_data.push_back(res);
			if (op != op_lea)
				m_cc = res[15] ? 3'b100 : (res == '0) ? 3'b010 : 3'b001;
		end
		pc = next_pc;
		steps++;
	end
	if (!done)
		abort_run("reference model never reached the closing branch");
endtask

task automatic run_program(input string name);
	int cycles;
	run_model();
	repeat (9) begin
		@(negedge clk);
		check_bit("pmem_read in reset", pmem_read, 1'b0);
		check_bit("reg_store in reset", reg_store, 1'b0);
	end
	@(posedge clk);
	arst_n <= 1'b1;
	cycles = 0;
	while (exp_dr.size() != 0 && cycles < prog_len * 8 + 40) begin
		@(negedge clk);
		cycles++;
	end
	if (exp_dr.size() != 0)
		abort_run($sformatf("%s: %0d register writes never retired", name, exp_dr.size()));
	repeat (20) @(negedge clk);
endtask

task automatic test_independent();
	hold_reset();
	clear_program();
	put(enc_alu(op_add, 3'd1, 3'd0, 1'b1, 5'd7));
	put(enc_alu(op_add, 3'd2, 3'd0, 1'b1, 5'(-6)));
	put(enc_not(3'd3, 3'd0));
	put(enc_alu(op_and, 3'd4, 3'd0, 1'b1, 5'(-1)));
	put(enc_alu(op_add, 3'd5, 3'd1, 1'b0, 5'd2));
	put(enc_alu(op_and, 3'd6, 3'd3, 1'b0, 5'd1));
	put(enc_not(3'd7, 3'd2));
	put(enc_alu(op_and, 3'd1, 3'd3, 1'b1, 5'd10));
	put(enc_off9(op_br, 3'b111, 9'h1ff));
	run_program("independent");
endtask

task automatic test_dependent();
	hold_reset();
	clear_program();
	put(enc_alu(op_add, 3'd1, 3'd0, 1'b1, 5'd9));
	put(enc_alu(op_add, 3'd1, 3'd1, 1'b1, 5'(-4)));
	put(enc_not(3'd2, 3'd1));
	put(enc_alu(op_and, 3'd3, 3'd2, 1'b0, 5'd1));
	put(enc_alu(op_add, 3'd3, 3'd3, 1'b0, 5'd3));
	put(enc_alu(op_add, 3'd4, 3'd3, 1'b1, 5'd15));
	put(enc_alu(op_and, 3'd4, 3'd4, 1'b1, 5'(-2)));
	put(enc_not(3'd4, 3'd4));
	put(enc_off9(op_br, 3'b111, 9'h1ff));
	run_program("dependent");
endtask

task automatic test_lea();
	hold_reset();
	clear_program();
	put(enc_off9(op_lea, 3'd1, 9'd5));
	put(enc_off9(op_lea, 3'd2, 9'(-3)));
	put(enc_alu(op_add, 3'd3, 3'd0, 1'b1, 5'(-1)));
	put(enc_off9(op_lea, 3'd4, 9'd0));
	// cc still negative, lea does not touch it
	put(enc_off9(op_br, 3'b100, 9'd1));
	put(enc_alu(op_add, 3'd5, 3'd0, 1'b1, 5'd1));
	put(enc_alu(op_add, 3'd6, 3'd1, 1'b0, 5'd2));
	put(enc_off9(op_br, 3'b111, 9'h1ff));
	run_program("lea");
endtask

task automatic test_branches();
	hold_reset();
	clear_program();
	put(enc_alu(op_and, 3'd1, 3'd1, 1'b1, 5'd0));
	put(enc_off9(op_br, 3'b010, 9'd2));
	put(enc_alu(op_add, 3'd2, 3'd0, 1'b1, 5'd1));
	put(enc_alu(op_add, 3'd3, 3'd0, 1'b1, 5'd2));
	put(enc_alu(op_add, 3'd4, 3'd0, 1'b1, 5'd3));
	put(enc_off9(op_br, 3'b100, 9'd1));
	put(enc_alu(op_add, 3'd5, 3'd0, 1'b1, 5'd4));
	put(enc_off9(op_br, 3'b001, 9'd0));
	put(enc_alu(op_add, 3'd6, 3'd0, 1'b1, 5'(-8)));
	put(enc_off9(op_br, 3'b011, 9'd1));
	put(enc_alu(op_add, 3'd7, 3'd0, 1'b1, 5'd5));
	put(enc_off9(op_br, 3'b111, 9'd2));
	put(enc_alu(op_add, 3'd2, 3'd0, 1'b1, 5'd6));
	put(enc_alu(op_add, 3'd3, 3'd0, 1'b1, 5'd7));
	put(enc_alu(op_add, 3'd1, 3'd1, 1'b1, 5'd1));
	put(enc_off9(op_br, 3'b111, 9'h1ff));
	run_program("branches");
endtask

task automatic test_reset_values();
	hold_reset();
	clear_program();
	// cc comes out of reset as zero
	put(enc_off9(op_br, 3'b010, 9'd1));
	put(enc_alu(op_add, 3'd1, 3'd0, 1'b1, 5'd1));
	put(enc_alu(op_add, 3'd1, 3'd2, 1'b0, 5'd3));
	put(enc_alu(op_add, 3'd4, 3'd5, 1'b1, 5'd0));
	put(enc_not(3'd6, 3'd7));
	put(enc_alu(op_and, 3'd0, 3'd0, 1'b0, 5'd1));
	put(enc_off9(op_br, 3'b111, 9'h1ff));
	run_program("reset values");
endtask

task automatic test_random();
	logic [15:0] v;
	int o;
	hold_reset();
	clear_program();
	for (int i = 0; i < RAND_LEN - 1; i++) begin
		take_bits(15, v);
		case (v[14:12])
			3'd0, 3'd1: put(enc_alu(op_add, v[11:9], v[8:6], v[5], v[4:0]));
			3'd2, 3'd3: put(enc_alu(op_and, v[11:9], v[8:6], v[5], v[4:0]));
			3'd4: put(enc_not(v[11:9], v[8:6]));
			3'd5: put(enc_off9(op_lea, v[11:9], v[8:0]));
			3'd6: begin
				// forward only, never past the closing branch
				o = v[1:0];
				if (o > RAND_LEN - 2 - i)
					o = RAND_LEN - 2 - i;
				put(enc_off9(op_br, v[11:9], 9'(o)));
			end
			default: put(enc_alu(op_add, v[11:9], v[8:6], 1'b1, v[4:0]));
		endcase
	end
	put(enc_off9(op_br, 3'b111, 9'h1ff));
	run_program("random");
endtask

initial begin
	#(WATCHDOG_NS);
	$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
	$display("*** FAILED ***");
	$fatal(1);
end

initial begin
	test_independent();
	test_dependent();
	test_lea();
	test_branches();
	test_reset_values();
	test_random();
	if (fails == 0 && exp_dr.size() == 0) begin
		$display("*** PASSED ***");
		$finish;
	end else begin
		$display("*** FAILED ***");
		$fatal(1);
	end
end

endmodule : mp3_tb

// File: files.f
+incdir+verilog
verilog/lc3b_types.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/pipeline_control.sv
verilog/mp3.sv
tb/mp3_tb.sv
